//--- source/serdes_test_pkg.sv
`default_nettype none

package serdes_test_pkg;

    // Word geometry of the link
    localparam int WORD_BITS = 8;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [2:0]           bit_cnt_t;

    // Pattern source, x^8+x^6+x^5+x^4+1 in Fibonacci form
    localparam word_t LFSR_SEED = 8'h01;
    localparam word_t LFSR_TAPS = 8'hB8;

    // Lock acquisition thresholds
    localparam logic [2:0] LOCK_COUNT = 3'd4;
    localparam logic [1:0] SLIP_HOLD  = 2'd2;

    // Received-word counter bit shown on the heartbeat lamp
    localparam int BEAT_BIT = 5;

    typedef enum logic [1:0] {
        HUNT   = 2'd0,
        HOLD   = 2'd1,
        LOCKED = 2'd2,
        FAILED = 2'd3
    } check_state_e;

    // Successor of a word in the pattern sequence
    // The feedback bit is the parity of the tapped bits and enters at the LSB
    function automatic word_t lfsr_next(input word_t cur);
        logic fb;
        fb = ^(cur & LFSR_TAPS);
        return {cur[WORD_BITS-2:0], fb};
    endfunction

endpackage

`default_nettype wire

//--- source/pattern_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_serializer (
    input  wire  CLK,
    input  wire  rst_n,
    input  wire  clear,
    output logic ser_out
);

    // Word currently on the line, kept whole for computing its successor
    serdes_test_pkg::word_t word_q;

    // Output shift register, MSB goes out first
    serdes_test_pkg::word_t shift_q;

    // Position of the bit on the line within the current word
    serdes_test_pkg::bit_cnt_t cnt_q;

    serdes_test_pkg::word_t next_word;
    logic                   last_bit;

    assign next_word = serdes_test_pkg::lfsr_next(word_q);
    assign last_bit  = (cnt_q == serdes_test_pkg::bit_cnt_t'(serdes_test_pkg::WORD_BITS - 1));

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (clear) begin
            cnt_q <= '0;
        end else begin
            // Counter wraps naturally at the word boundary
            cnt_q <= cnt_q + 3'd1;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            word_q <= serdes_test_pkg::LFSR_SEED;
        end else if (clear) begin
            word_q <= serdes_test_pkg::LFSR_SEED;
        end else if (last_bit) begin
            word_q <= next_word;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= serdes_test_pkg::LFSR_SEED;
        end else if (clear) begin
            shift_q <= serdes_test_pkg::LFSR_SEED;
        end else if (last_bit) begin
            // Next word follows the last bit with no gap
            shift_q <= next_word;
        end else begin
            shift_q <= {shift_q[serdes_test_pkg::WORD_BITS-2:0], 1'b0};
        end
    end

    assign ser_out = shift_q[serdes_test_pkg::WORD_BITS-1];

endmodule

`default_nettype wire

//--- source/word_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module word_deserializer (
    input  wire                    CLK,
    input  wire                    rst_n,
    input  wire                    clear,
    input  wire                    ser_in,
    input  wire                    slip,
    output serdes_test_pkg::word_t word,
    output logic                   word_tick
);

    // Sampled bits, newest at the LSB so the first bit ends up as MSB
    serdes_test_pkg::word_t shift_q;

    serdes_test_pkg::bit_cnt_t cnt_q;
    logic                      tick_q;
    logic                      boundary;

    // A slip holds the counter for one sample, so it never lands on a boundary
    assign boundary = (cnt_q == serdes_test_pkg::bit_cnt_t'(serdes_test_pkg::WORD_BITS - 1))
                      && !slip;

    always_ff @(posedge CLK) begin
        shift_q <= {shift_q[serdes_test_pkg::WORD_BITS-2:0], ser_in};
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (clear) begin
            cnt_q <= '0;
        end else if (!slip) begin
            cnt_q <= cnt_q + 3'd1;
        end
    end

    // Strobe appears together with the completed word in the shift register
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            tick_q <= 1'b0;
        end else if (clear) begin
            tick_q <= 1'b0;
        end else begin
            tick_q <= boundary;
        end
    end

    assign word      = shift_q;
    assign word_tick = tick_q;

endmodule

`default_nettype wire

//--- source/link_checker.sv
`timescale 1ns/1ps
`default_nettype none

module link_checker (
    input  wire                    CLK,
    input  wire                    rst_n,
    input  wire                    clear,
    input  serdes_test_pkg::word_t word,
    input  wire                    word_tick,
    output logic                   slip,
    output logic                   led_ok,
    output logic                   led_beat
);

    serdes_test_pkg::check_state_e state_q;
    serdes_test_pkg::check_state_e state_d;

    serdes_test_pkg::word_t prev_q;
    logic [2:0]             good_cnt_q;
    logic [2:0]             good_cnt_d;
    logic [1:0]             hold_cnt_q;
    logic [1:0]             hold_cnt_d;
    logic                   slip_q;
    logic                   slip_d;
    logic [serdes_test_pkg::BEAT_BIT:0] beat_cnt_q;

    logic good;

    // A word is good only if it follows the previous one; all-zero never is
    assign good = (word != '0) && (word == serdes_test_pkg::lfsr_next(prev_q));

    always_comb begin
        state_d    = state_q;
        good_cnt_d = good_cnt_q;
        hold_cnt_d = hold_cnt_q;
        slip_d     = 1'b0;

        if (word_tick) begin
            case (state_q)
                serdes_test_pkg::HUNT: begin
                    if (!good) begin
                        slip_d     = 1'b1;
                        good_cnt_d = '0;
                        hold_cnt_d = '0;
                        state_d    = serdes_test_pkg::HOLD;
                    end else if (good_cnt_q == serdes_test_pkg::LOCK_COUNT - 3'd1) begin
                        state_d = serdes_test_pkg::LOCKED;
                    end else begin
                        good_cnt_d = good_cnt_q + 3'd1;
                    end
                end
                serdes_test_pkg::HOLD: begin
                    // Let the deserializer settle on the new boundary
                    if (hold_cnt_q == serdes_test_pkg::SLIP_HOLD - 2'd1) begin
                        state_d = serdes_test_pkg::HUNT;
                    end else begin
                        hold_cnt_d = hold_cnt_q + 2'd1;
                    end
                end
                serdes_test_pkg::LOCKED: begin
                    if (!good) begin
                        state_d = serdes_test_pkg::FAILED;
                    end
                end
                default: begin
                    // FAILED stays until reset or clear
                    state_d = serdes_test_pkg::FAILED;
                end
            endcase
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= serdes_test_pkg::HUNT;
            good_cnt_q <= '0;
            hold_cnt_q <= '0;
            slip_q     <= 1'b0;
        end else if (clear) begin
            state_q    <= serdes_test_pkg::HUNT;
            good_cnt_q <= '0;
            hold_cnt_q <= '0;
            slip_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            good_cnt_q <= good_cnt_d;
            hold_cnt_q <= hold_cnt_d;
            slip_q     <= slip_d;
        end
    end

    // Previous word is tracked in every state, held words included
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            prev_q <= '0;
        end else if (clear) begin
            prev_q <= '0;
        end else if (word_tick) begin
            prev_q <= word;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
        end else if (clear) begin
            beat_cnt_q <= '0;
        end else if (word_tick) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    assign slip     = slip_q;
    assign led_ok   = (state_q == serdes_test_pkg::LOCKED);
    assign led_beat = beat_cnt_q[serdes_test_pkg::BEAT_BIT];

endmodule

`default_nettype wire

//--- source/serdes_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_test_top (
    input  wire  CLK,
    input  wire  rst_n,
    input  wire  clear,
    input  wire  ser_in,
    output logic ser_out,
    output logic led_ok,
    output logic led_beat
);

    // Receive path between deserializer and checker
    serdes_test_pkg::word_t word;
    logic                   word_tick;
    logic                   slip;

    pattern_serializer u_pattern_serializer (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .clear   (clear),
        .ser_out (ser_out)
    );

    word_deserializer u_word_deserializer (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .clear     (clear),
        .ser_in    (ser_in),
        .slip      (slip),
        .word      (word),
        .word_tick (word_tick)
    );

    link_checker u_link_checker (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .clear     (clear),
        .word      (word),
        .word_tick (word_tick),
        .slip      (slip),
        .led_ok    (led_ok),
        .led_beat  (led_beat)
    );

endmodule

`default_nettype wire

//--- bench/serdes_test_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_test_asserts (
    input wire                           CLK,
    input wire                           rst_n,
    input wire                           clear,
    input wire                           word_tick,
    input wire                           slip,
    input wire                           led_ok,
    input serdes_test_pkg::check_state_e state
);

    // Cycles since the last word strobe
    int   gap;
    logic seen;

    always @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            gap  <= 0;
            seen <= 1'b0;
        end else if (clear) begin
            gap  <= 0;
            seen <= 1'b0;
        end else if (word_tick) begin
            gap  <= 0;
            seen <= 1'b1;
        end else begin
            gap <= gap + 1;
        end
    end

    slip_not_locked: assert property (@(posedge CLK) disable iff (!rst_n)
        slip |-> (state != serdes_test_pkg::LOCKED && state != serdes_test_pkg::FAILED))
        else $error("slip raised while locked or failed");

    // Eight samples per word, nine once after a slip
    tick_spacing: assert property (@(posedge CLK) disable iff (!rst_n || clear)
        (word_tick && seen) |-> (gap == 7 || gap == 8))
        else $error("word strobes not 8 or 9 cycles apart");

    ok_means_locked: assert property (@(posedge CLK) disable iff (!rst_n)
        led_ok |-> (state == serdes_test_pkg::LOCKED))
        else $error("led_ok high outside the locked state");

endmodule

bind link_checker serdes_test_asserts asserts0 (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .clear     (clear),
    .word_tick (word_tick),
    .slip      (slip),
    .led_ok    (led_ok),
    .state     (state_q)
);

`default_nettype wire

//--- bench/serdes_test_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_test_monitor (
    input  wire        CLK,
    input  wire        rst_n,
    input  wire        clear,
    input  wire        ser_out,
    input  wire        led_ok,
    input  wire        led_beat,
    input  wire  [2:0] phase,
    output logic       lock_done,
    output int         err_count
);

    localparam logic [2:0] PH_LOCK   = 3'd1;
    localparam logic [2:0] PH_STABLE = 3'd2;
    localparam logic [2:0] PH_ERR    = 3'd3;
    localparam logic [2:0] PH_STUCK  = 3'd5;
    localparam logic [2:0] PH_DONE   = 3'd6;

    localparam int LOCK_LIMIT = 800;
    localparam int FALL_LIMIT = 24;

    logic [7:0] exp_word = 8'h01;
    logic [7:0] rx_word  = 8'h00;
    int         bit_pos  = 0;
    int         words    = 0;
    logic [2:0] last_phase = 3'd0;
    int         phase_cyc  = 0;
    logic       reported   = 1'b0;
    int         cyc        = 0;
    int         last_edge  = 0;
    logic       edge_valid = 1'b0;
    logic       ok_all     = 1'b0;
    logic       beat_prev  = 1'b0;
    int         beat_edges = 0;

    initial begin
        lock_done = 1'b0;
        err_count = 0;
    end

    // Successor by x^8+x^6+x^5+x^4+1 with taps at bits 7, 5, 4 and 3
    function automatic logic [7:0] ref_next(input logic [7:0] w);
        return {w[6:0], w[7] ^ w[5] ^ w[4] ^ w[3]};
    endfunction

    // Transmit sequence is grouped MSB first from the cycle after reset or clear
    always @(posedge CLK) begin
        if (!rst_n || clear) begin
            bit_pos  = 0;
            exp_word = 8'h01;
        end else begin
            rx_word = {rx_word[6:0], ser_out};
            if (bit_pos == 7) begin
                if (rx_word !== exp_word) begin
                    $display("MISMATCH time=%0t signal=ser_out expected=%h actual=%h",
                             $time, exp_word, rx_word);
                    err_count = err_count + 1;
                end
                words    = words + 1;
                exp_word = ref_next(exp_word);
                bit_pos  = 0;
            end else begin
                bit_pos = bit_pos + 1;
            end
        end
    end

    always @(posedge CLK) begin
        if (phase != last_phase) begin
            phase_cyc = 0;
        end else begin
            phase_cyc = phase_cyc + 1;
        end
        last_phase = phase;

        case (phase)
            PH_LOCK: begin
                if (led_ok) begin
                    lock_done = 1'b1;
                end else if (phase_cyc >= LOCK_LIMIT && !lock_done) begin
                    $display("Link did not lock within %0d cycles at time %0t",
                             LOCK_LIMIT, $time);
                    err_count = err_count + 1;
                    lock_done = 1'b1;
                end
            end
            PH_STABLE: begin
                if (led_ok !== 1'b1) begin
                    $display("MISMATCH time=%0t signal=led_ok expected=1 actual=%0b",
                             $time, led_ok);
                    err_count = err_count + 1;
                end
            end
            PH_ERR: begin
                if (phase_cyc >= FALL_LIMIT && led_ok !== 1'b0) begin
                    $display("MISMATCH time=%0t signal=led_ok expected=0 actual=%0b",
                             $time, led_ok);
                    err_count = err_count + 1;
                end
            end
            PH_STUCK: begin
                if (led_ok !== 1'b0) begin
                    $display("MISMATCH time=%0t signal=led_ok expected=0 actual=%0b",
                             $time, led_ok);
                    err_count = err_count + 1;
                end
            end
            PH_DONE: begin
                if (!reported) begin
                    if (beat_edges < 4) begin
                        $display("Heartbeat lamp toggled only %0d times", beat_edges);
                        err_count = err_count + 1;
                    end
                    $display("Summary: %0d errors, %0d words checked, %0d heartbeat edges",
                             err_count, words, beat_edges);
                    reported = 1'b1;
                end
            end
            default: begin
            end
        endcase

        if (phase != PH_LOCK) begin
            lock_done = 1'b0;
        end
    end

    // Heartbeat edges are exactly 256 cycles apart when locked for the whole interval
    always @(posedge CLK) begin
        cyc = cyc + 1;
        if (!rst_n || clear) begin
            edge_valid = 1'b0;
            beat_prev  = 1'b0;
        end else begin
            ok_all = ok_all & led_ok;
            if (led_beat != beat_prev) begin
                if (edge_valid) begin
                    if (cyc - last_edge < 256 || cyc - last_edge > 288) begin
                        $display("MISMATCH time=%0t signal=led_beat expected=256..288 actual=%0d",
                                 $time, cyc - last_edge);
                        err_count = err_count + 1;
                    end else if (ok_all && cyc - last_edge != 256) begin
                        $display("MISMATCH time=%0t signal=led_beat expected=256 actual=%0d",
                                 $time, cyc - last_edge);
                        err_count = err_count + 1;
                    end
                end
                beat_edges = beat_edges + 1;
                last_edge  = cyc;
                edge_valid = 1'b1;
                ok_all     = led_ok;
            end
            beat_prev = led_beat;
        end
    end

endmodule

`default_nettype wire

//--- bench/serdes_test_tb.sv
`timescale 1ns/1ps
`default_nettype none

module serdes_test_tb;

    localparam logic [2:0] PH_IDLE   = 3'd0;
    localparam logic [2:0] PH_LOCK   = 3'd1;
    localparam logic [2:0] PH_STABLE = 3'd2;
    localparam logic [2:0] PH_ERR    = 3'd3;
    localparam logic [2:0] PH_CLEAR  = 3'd4;
    localparam logic [2:0] PH_STUCK  = 3'd5;
    localparam logic [2:0] PH_DONE   = 3'd6;

    localparam int LOCK_CYCLES    = 800;
    localparam int STABLE_CYCLES  = 64 * 8;
    localparam int ERR_CYCLES     = 24 + 40 * 8;
    localparam int STUCK_CYCLES   = 100 * 8;
    localparam int TIMEOUT_CYCLES = 2 * LOCK_CYCLES + 2 * STABLE_CYCLES + ERR_CYCLES
                                    + STUCK_CYCLES + 40 + 200;

    logic       CLK      = 1'b0;
    logic       rst_n    = 1'b0;
    logic       clear    = 1'b0;
    logic       ser_in   = 1'b0;
    logic [2:0] phase    = PH_IDLE;
    logic [2:0] delay    = 3'd0;
    logic [7:0] line_q   = 8'h00;
    logic       flip_req = 1'b0;
    logic       stuck    = 1'b0;

    wire ser_out;
    wire led_ok;
    wire led_beat;
    wire lock_done;
    int  err_count;

    serdes_test_top dut0 (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .clear    (clear),
        .ser_in   (ser_in),
        .ser_out  (ser_out),
        .led_ok   (led_ok),
        .led_beat (led_beat)
    );

    serdes_test_monitor mon0 (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .clear     (clear),
        .ser_out   (ser_out),
        .led_ok    (led_ok),
        .led_beat  (led_beat),
        .phase     (phase),
        .lock_done (lock_done),
        .err_count (err_count)
    );

    initial begin
        forever #5 CLK = ~CLK;
    end

    // External loopback with a delay of d cycles, one-shot bit flip and stuck-at-zero
    always @(negedge CLK) begin
        line_q = {line_q[6:0], ser_out};
        if (stuck) begin
            ser_in = 1'b0;
        end else begin
            ser_in = line_q[delay] ^ flip_req;
        end
        flip_req = 1'b0;
    end

    task automatic wait_for_lock();
        @(negedge CLK);
        while (!lock_done) begin
            @(negedge CLK);
        end
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        phase = PH_CLEAR;
        @(negedge CLK);
        clear = 1'b0;
    endtask

    initial begin
        delay = 3'($urandom(67798) % 8);
        repeat (2) @(negedge CLK);
        rst_n = 1'b1;
        phase = PH_LOCK;
        wait_for_lock();
        phase = PH_STABLE;
        repeat (STABLE_CYCLES) @(negedge CLK);

        // One flipped bit at a random position
        repeat ($urandom % 8) @(negedge CLK);
        @(posedge CLK);
        flip_req = 1'b1;
        @(negedge CLK);
        phase = PH_ERR;
        repeat (ERR_CYCLES) @(negedge CLK);

        delay = 3'($urandom % 8);
        pulse_clear();
        phase = PH_LOCK;
        wait_for_lock();
        phase = PH_STABLE;
        repeat (STABLE_CYCLES) @(negedge CLK);

        @(posedge CLK);
        stuck = 1'b1;
        @(negedge CLK);
        pulse_clear();
        phase = PH_STUCK;
        repeat (STUCK_CYCLES) @(negedge CLK);

        phase = PH_DONE;
        repeat (3) @(negedge CLK);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Watchdog expired after %0d cycles in phase %0d", TIMEOUT_CYCLES, phase);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- serdes_test.f
source/serdes_test_pkg.sv
source/pattern_serializer.sv
source/word_deserializer.sv
source/link_checker.sv
source/serdes_test_top.sv
bench/serdes_test_asserts.sv
bench/serdes_test_monitor.sv
bench/serdes_test_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module serdes_test_tb \
    -f serdes_test.f \
    -o serdes_test_sim

output="$(./obj_dir/serdes_test_sim)"
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
else
    exit 1
fi
